/* logic/mac_pkg.sv */
// Multiply-accumulate shared definitions
package mac_pkg;

  // Signed operand width.
  localparam int unsigned OP_WIDTH = 16;
  // Accumulator and result width, wraps modulo 2^32.
  localparam int unsigned ACC_WIDTH = 32;

  // Operand memory entries, also the longest job.
  localparam int unsigned MEM_DEPTH = 16;
  // Length field, zero encodes a full memory.
  localparam int unsigned LEN_WIDTH = 4;

  // Host register port address width.
  localparam int unsigned ADDR_WIDTH = 5;

  // Register map.
  localparam logic [ADDR_WIDTH-1:0] REG_TRIGGER = 5'd0;
  localparam logic [ADDR_WIDTH-1:0] REG_LEN     = 5'd1;
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS  = 5'd2;
  localparam logic [ADDR_WIDTH-1:0] REG_RESULT  = 5'd3;
  // Operand words from here up, a in the upper half and b in the lower half.
  localparam logic [ADDR_WIDTH-1:0] MEM_BASE    = 5'd16;

  // One operand pair on its way to the engine.
  typedef struct packed {
    logic signed [OP_WIDTH-1:0] a;
    logic signed [OP_WIDTH-1:0] b;
    // Final pair of the job.
    logic                       last;
  } mac_pair_t;

endpackage

/* logic/mac_fifo.sv */
// Credit-returning FIFO
module mac_fifo #(
  parameter int unsigned FIFO_DEPTH = 4,
  parameter type         payload_t  = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output logic     valid_o,
  output payload_t data_o,
  output logic     credit_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t          mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_pop;
  logic              credit_q;

  // Pushes never see a full buffer, the credits rule that out.
  assign do_pop = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at the depth.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
      // One credit back per pop.
      credit_q <= do_pop;
    end
  end

  assign valid_o  = (count_q != '0);
  assign data_o   = mem[rd_ptr_q];
  assign credit_o = credit_q;

endmodule

/* logic/mac_source.sv */
// Operand pair source
module mac_source #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  start_i,
  input  logic [mac_pkg::LEN_WIDTH-1:0]         len_i,
  // Host side of the operand memory.
  input  logic                                  mem_we_i,
  input  logic [$clog2(mac_pkg::MEM_DEPTH)-1:0] mem_addr_i,
  input  logic [2*mac_pkg::OP_WIDTH-1:0]        mem_wdata_i,
  output logic [2*mac_pkg::OP_WIDTH-1:0]        mem_rdata_o,
  // Credit-based push into the FIFO.
  output logic                                  push_o,
  output mac_pkg::mac_pair_t                    pair_o,
  input  logic                                  credit_i
);

  localparam int unsigned MEM_AW = $clog2(mac_pkg::MEM_DEPTH);
  localparam int unsigned CNT_W  = mac_pkg::LEN_WIDTH + 1;
  localparam int unsigned CR_W   = $clog2(FIFO_DEPTH + 1);

  logic [2*mac_pkg::OP_WIDTH-1:0] mem [mac_pkg::MEM_DEPTH];
  logic [2*mac_pkg::OP_WIDTH-1:0] rd_word;
  logic [MEM_AW-1:0]              rd_ptr_q;
  logic [CNT_W-1:0]               remain_q;
  logic [CR_W-1:0]                credits_q;

  // Operand memory, two read ports.
  always_ff @(posedge clk_i) begin
    if (mem_we_i) begin
      mem[mem_addr_i] <= mem_wdata_i;
    end
  end

  assign mem_rdata_o = mem[mem_addr_i];
  assign rd_word     = mem[rd_ptr_q];

  // Push whenever pairs remain and the FIFO has room.
  assign push_o      = (remain_q != '0) && (credits_q != '0);
  assign pair_o.a    = rd_word[2*mac_pkg::OP_WIDTH-1:mac_pkg::OP_WIDTH];
  assign pair_o.b    = rd_word[mac_pkg::OP_WIDTH-1:0];
  assign pair_o.last = (remain_q == CNT_W'(1));

  // Read pointer and remaining count.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      remain_q <= '0;
    end else if (start_i) begin
      rd_ptr_q <= '0;
      // Zero length means the whole memory.
      remain_q <= (len_i == '0) ? CNT_W'(mac_pkg::MEM_DEPTH) : CNT_W'(len_i);
    end else if (push_o) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

  // Credit counter.
  // Push spends one, each returned pulse refunds one.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits_q <= CR_W'(FIFO_DEPTH);
    end else begin
      case ({push_o, credit_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

endmodule

/* logic/mac_engine.sv */
// Serial multiply-accumulate engine
module mac_engine (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          start_i,
  input  logic                          valid_i,
  input  mac_pkg::mac_pair_t            pair_i,
  output logic                          pop_o,
  output logic                          done_o,
  output logic [mac_pkg::ACC_WIDTH-1:0] result_o
);

  localparam int unsigned STEP_W = $clog2(mac_pkg::OP_WIDTH);

  typedef enum logic [1:0] {
    EN_IDLE,
    EN_MUL,
    EN_ACC
  } state_e;

  state_e                        state_q;
  logic [STEP_W-1:0]             step_q;
  logic [mac_pkg::ACC_WIDTH-1:0] acc_q;
  logic                          done_q;
  logic [mac_pkg::ACC_WIDTH-1:0] mcand_q;
  logic [mac_pkg::OP_WIDTH-1:0]  mplier_q;
  logic [mac_pkg::ACC_WIDTH-1:0] prod_q;
  logic                          last_q;
  logic                          last_step;

  // Take a pair only when idle.
  assign pop_o     = (state_q == EN_IDLE) && valid_i;
  assign last_step = (step_q == STEP_W'(mac_pkg::OP_WIDTH - 1));

  // Control and accumulator.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= EN_IDLE;
      step_q  <= '0;
      acc_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      // New job starts from zero.
      if (start_i) begin
        acc_q <= '0;
      end
      case (state_q)
        EN_IDLE: begin
          if (pop_o) begin
            state_q <= EN_MUL;
            step_q  <= '0;
          end
        end
        EN_MUL: begin
          step_q <= step_q + 1'b1;
          if (last_step) begin
            state_q <= EN_ACC;
          end
        end
        EN_ACC: begin
          acc_q   <= acc_q + prod_q;
          done_q  <= last_q;
          state_q <= EN_IDLE;
        end
        default: state_q <= EN_IDLE;
      endcase
    end
  end

  // Shift-add datapath.
  // Sign bit of b carries negative weight, so the last step subtracts.
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      mcand_q  <= mac_pkg::ACC_WIDTH'(signed'(pair_i.a));
      mplier_q <= pair_i.b;
      prod_q   <= '0;
      last_q   <= pair_i.last;
    end else if (state_q == EN_MUL) begin
      if (mplier_q[0]) begin
        prod_q <= last_step ? prod_q - mcand_q : prod_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign done_o   = done_q;
  assign result_o = acc_q;

endmodule

/* logic/mac_ctrl.sv */
// Multiply-accumulate controller
module mac_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Host register port.
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  logic [mac_pkg::ADDR_WIDTH-1:0]        addr_i,
  input  logic [mac_pkg::ACC_WIDTH-1:0]         wdata_i,
  output logic [mac_pkg::ACC_WIDTH-1:0]         rdata_o,
  output logic                                  rvalid_o,
  output logic                                  evt_o,
  // Job control towards the source and engine.
  output logic                                  start_o,
  output logic [mac_pkg::LEN_WIDTH-1:0]         len_o,
  // Operand memory port, memory lives in the source.
  output logic                                  mem_we_o,
  output logic [$clog2(mac_pkg::MEM_DEPTH)-1:0] mem_addr_o,
  output logic [2*mac_pkg::OP_WIDTH-1:0]        mem_wdata_o,
  input  logic [2*mac_pkg::OP_WIDTH-1:0]        mem_rdata_i,
  // Engine completion.
  input  logic                                  done_i,
  input  logic [mac_pkg::ACC_WIDTH-1:0]         result_i
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  state_e                         state_q;
  logic [mac_pkg::LEN_WIDTH-1:0]  len_q;
  logic [mac_pkg::ACC_WIDTH-1:0]  result_q;
  logic [mac_pkg::ACC_WIDTH-1:0]  rdata_q;
  logic                           rvalid_q;
  logic                           start_q;
  logic                           evt_q;
  logic                           is_mem;
  logic                           wr_trigger;
  logic                           wr_len;

  // Address decode.
  assign is_mem     = (addr_i >= mac_pkg::MEM_BASE);
  assign wr_trigger = req_i && we_i && (addr_i == mac_pkg::REG_TRIGGER);
  assign wr_len     = req_i && we_i && (addr_i == mac_pkg::REG_LEN);

  // Memory writes pass straight through, taken at this edge.
  assign mem_we_o    = req_i && we_i && is_mem;
  assign mem_addr_o  = addr_i[$clog2(mac_pkg::MEM_DEPTH)-1:0];
  assign mem_wdata_o = wdata_i;

  // Length register.
  // Writable at any time.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      len_q <= '0;
    end else if (wr_len) begin
      len_q <= wdata_i[mac_pkg::LEN_WIDTH-1:0];
    end
  end

  // Job FSM.
  // Trigger only counts while idle.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= ST_IDLE;
      start_q  <= 1'b0;
      evt_q    <= 1'b0;
      result_q <= '0;
    end else begin
      start_q <= 1'b0;
      evt_q   <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (wr_trigger) begin
            state_q <= ST_BUSY;
            start_q <= 1'b1;
          end
        end
        ST_BUSY: begin
          // Latch result, clear busy and raise the event together.
          if (done_i) begin
            state_q  <= ST_IDLE;
            evt_q    <= 1'b1;
            result_q <= result_i;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Read valid, one cycle after the request.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i && !we_i;
    end
  end

  // Read data mux.
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      if (is_mem) begin
        rdata_q <= mem_rdata_i;
      end else begin
        case (addr_i)
          mac_pkg::REG_LEN:    rdata_q <= mac_pkg::ACC_WIDTH'(len_q);
          mac_pkg::REG_STATUS: rdata_q <= mac_pkg::ACC_WIDTH'(state_q == ST_BUSY);
          mac_pkg::REG_RESULT: rdata_q <= result_q;
          // Trigger and holes read as zero.
          default:             rdata_q <= '0;
        endcase
      end
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;
  assign evt_o    = evt_q;
  assign start_o  = start_q;
  assign len_o    = len_q;

endmodule

/* logic/mac_top.sv */
// Multiply-accumulate accelerator top
module mac_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [mac_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [mac_pkg::ACC_WIDTH-1:0]  wdata_i,
  output logic [mac_pkg::ACC_WIDTH-1:0]  rdata_o,
  output logic                           rvalid_o,
  output logic                           evt_o
);

  logic                                  start;
  logic [mac_pkg::LEN_WIDTH-1:0]         len;
  logic                                  mem_we;
  logic [$clog2(mac_pkg::MEM_DEPTH)-1:0] mem_addr;
  logic [2*mac_pkg::OP_WIDTH-1:0]        mem_wdata;
  logic [2*mac_pkg::OP_WIDTH-1:0]        mem_rdata;
  logic                                  done;
  logic [mac_pkg::ACC_WIDTH-1:0]         result;
  logic                                  push;
  mac_pkg::mac_pair_t                    push_pair;
  logic                                  credit;
  logic                                  fifo_valid;
  mac_pkg::mac_pair_t                    fifo_pair;
  logic                                  pop;

  // Host port, registers and job FSM.
  mac_ctrl i_ctrl (
    .clk_i       ( clk_i     ), .rst_i       ( rst_i     ),
    .req_i       ( req_i     ), .we_i        ( we_i      ),
    .addr_i      ( addr_i    ), .wdata_i     ( wdata_i   ),
    .rdata_o     ( rdata_o   ), .rvalid_o    ( rvalid_o  ),
    .evt_o       ( evt_o     ), .start_o     ( start     ),
    .len_o       ( len       ), .mem_we_o    ( mem_we    ),
    .mem_addr_o  ( mem_addr  ), .mem_wdata_o ( mem_wdata ),
    .mem_rdata_i ( mem_rdata ), .done_i      ( done      ),
    .result_i    ( result    )
  );

  // Producer.
  mac_source #(.FIFO_DEPTH(FIFO_DEPTH)) i_source (
    .clk_i       ( clk_i     ), .rst_i       ( rst_i     ),
    .start_i     ( start     ), .len_i       ( len       ),
    .mem_we_i    ( mem_we    ), .mem_addr_i  ( mem_addr  ),
    .mem_wdata_i ( mem_wdata ), .mem_rdata_o ( mem_rdata ),
    .push_o      ( push      ), .pair_o      ( push_pair ),
    .credit_i    ( credit    )
  );

  // Buffer between producer and engine.
  mac_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(mac_pkg::mac_pair_t)) i_fifo (
    .clk_i    ( clk_i      ), .rst_i   ( rst_i     ),
    .push_i   ( push       ), .data_i  ( push_pair ),
    .pop_i    ( pop        ), .valid_o ( fifo_valid ),
    .data_o   ( fifo_pair  ), .credit_o ( credit   )
  );

  // Consumer.
  mac_engine i_engine (
    .clk_i   ( clk_i      ), .rst_i    ( rst_i     ),
    .start_i ( start      ), .valid_i  ( fifo_valid ),
    .pair_i  ( fifo_pair  ), .pop_o    ( pop       ),
    .done_o  ( done       ), .result_o ( result    )
  );

endmodule

/* tb/tb_mac_top.sv */
// Multiply-accumulate accelerator testbench
module tb_mac_top;

  localparam int FIFO_DEPTH   = 4;
  localparam int READ_TIMEOUT = 8;
  localparam int EVT_TIMEOUT  = 2000;

  logic                           clk_i;
  logic                           rst_i;
  logic                           req_i;
  logic                           we_i;
  logic [mac_pkg::ADDR_WIDTH-1:0] addr_i;
  logic [mac_pkg::ACC_WIDTH-1:0]  wdata_i;
  logic [mac_pkg::ACC_WIDTH-1:0]  rdata_o;
  logic                           rvalid_o;
  logic                           evt_o;

  // Event pulses seen so far, and the count when the last job was triggered.
  int                             evt_count;
  int                             evt_base;
  // Operand image as the host last wrote it.
  logic signed [15:0]             op_a [16];
  logic signed [15:0]             op_b [16];
  logic [31:0]                    rdata;
  logic [31:0]                    expected;
  int                             n;

  mac_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (
    .clk_i    ( clk_i    ), .rst_i    ( rst_i    ),
    .req_i    ( req_i    ), .we_i     ( we_i     ),
    .addr_i   ( addr_i   ), .wdata_i  ( wdata_i  ),
    .rdata_o  ( rdata_o  ), .rvalid_o ( rvalid_o ),
    .evt_o    ( evt_o    )
  );

  // Period of 8.
  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (rst_i) begin
      evt_count <= 0;
    end else if (evt_o) begin
      evt_count <= evt_count + 1;
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // Event is a single-cycle pulse.
  evt_single: assert property (@(posedge clk_i) disable iff (rst_i) evt_o |=> !evt_o)
    else fail_run("evt_o stayed high for more than one cycle");

  // Read valid follows each read request by exactly one cycle and is low otherwise.
  rvalid_timing: assert property (@(posedge clk_i) disable iff (rst_i)
                                  rvalid_o == $past(req_i && !we_i))
    else fail_run("rvalid_o was not high exactly one cycle after a read request");

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic reg_write(input logic [mac_pkg::ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= 1'b1;
    addr_i  <= addr;
    wdata_i <= data;
    @(posedge clk_i);
    req_i   <= 1'b0;
    we_i    <= 1'b0;
  endtask

  task automatic reg_read(input logic [mac_pkg::ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    int waited;
    @(posedge clk_i);
    req_i  <= 1'b1;
    we_i   <= 1'b0;
    addr_i <= addr;
    @(posedge clk_i);
    req_i  <= 1'b0;
    // Sample between edges.
    @(negedge clk_i);
    for (waited = 0; waited < READ_TIMEOUT && rvalid_o !== 1'b1; waited++) begin
      @(negedge clk_i);
    end
    if (rvalid_o !== 1'b1) begin
      fail_run($sformatf("Read of address 0x%h never returned rvalid_o", addr));
    end else begin
      data = rdata_o;
    end
  endtask

  task automatic random_operands(input int count);
    for (int i = 0; i < count; i++) begin
      op_a[i] = 16'($urandom);
      op_b[i] = 16'($urandom);
    end
  endtask

  // Operand a in the upper half of each word.
  task automatic write_operands(input int count);
    for (int i = 0; i < count; i++) begin
      reg_write(mac_pkg::MEM_BASE + mac_pkg::ADDR_WIDTH'(i), {op_a[i], op_b[i]});
    end
  endtask

  // Wrapped sum of signed products.
  function automatic logic [31:0] model_result(input int count);
    logic [31:0] acc;
    acc = '0;
    for (int i = 0; i < count; i++) begin
      acc = acc + 32'(longint'(op_a[i]) * longint'(op_b[i]));
    end
    return acc;
  endfunction

  // Length 16 goes in as 0.
  task automatic start_job(input int count);
    reg_write(mac_pkg::REG_LEN, 32'(count % 16));
    evt_base = evt_count;
    reg_write(mac_pkg::REG_TRIGGER, 32'd1);
  endtask

  task automatic wait_event();
    int waited;
    for (waited = 0; waited < EVT_TIMEOUT && evt_count == evt_base; waited++) begin
      @(negedge clk_i);
    end
    if (evt_count == evt_base) begin
      fail_run("No evt_o pulse within 2000 cycles of the trigger");
    end
  endtask

  task automatic run_and_check(input int count);
    logic [31:0] value;
    start_job(count);
    reg_read(mac_pkg::REG_STATUS, value);
    check_value("STATUS", value, 32'd1);
    check_value("evt_count", 32'(evt_count), 32'(evt_base));
    wait_event();
    reg_read(mac_pkg::REG_STATUS, value);
    check_value("STATUS", value, 32'd0);
    reg_read(mac_pkg::REG_RESULT, value);
    check_value("RESULT", value, model_result(count));
  endtask

  initial begin
    clk_i   = 1'b0;
    rst_i   = 1'b1;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    void'($urandom(12088));
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    // Reset state.
    @(negedge clk_i);
    check_value("evt_o", 32'(evt_o), 32'd0);
    check_value("rvalid_o", 32'(rvalid_o), 32'd0);
    reg_read(mac_pkg::REG_STATUS, rdata);
    check_value("STATUS", rdata, 32'd0);
    reg_read(mac_pkg::REG_RESULT, rdata);
    check_value("RESULT", rdata, 32'd0);

    // Operand words and LEN read back.
    random_operands(16);
    write_operands(16);
    for (int i = 0; i < 16; i++) begin
      reg_read(mac_pkg::MEM_BASE + mac_pkg::ADDR_WIDTH'(i), rdata);
      check_value("operand word", rdata, {op_a[i], op_b[i]});
    end
    reg_write(mac_pkg::REG_LEN, 32'd9);
    reg_read(mac_pkg::REG_LEN, rdata);
    check_value("LEN", rdata, 32'd9);

    // Random job.
    n = $urandom_range(15, 1);
    random_operands(n);
    write_operands(n);
    run_and_check(n);

    // Full memory of extreme operands that wraps past 2^32.
    for (int i = 0; i < 16; i++) begin
      op_a[i] = (i == 14) ? 16'sh7fff : 16'sh8000;
      op_b[i] = (i >= 14) ? 16'sh7fff : 16'sh8000;
    end
    write_operands(16);
    run_and_check(16);

    // Second trigger while busy is dropped.
    random_operands(3);
    write_operands(3);
    expected = model_result(3);
    start_job(3);
    reg_write(mac_pkg::REG_TRIGGER, 32'd1);
    wait_event();
    // Long enough for a stray job to finish.
    repeat (200) @(negedge clk_i);
    check_value("evt_count", 32'(evt_count), 32'(evt_base + 1));
    reg_read(mac_pkg::REG_RESULT, rdata);
    check_value("RESULT", rdata, expected);

    // Back-to-back jobs restart the accumulator.
    random_operands(7);
    write_operands(7);
    run_and_check(7);
    random_operands(5);
    write_operands(5);
    run_and_check(5);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* list.f */
logic/mac_pkg.sv
logic/mac_fifo.sv
logic/mac_source.sv
logic/mac_engine.sv
logic/mac_ctrl.sv
logic/mac_top.sv
tb/tb_mac_top.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_mac_top \
  -f list.f

./obj_dir/Vtb_mac_top
